// ==== vlog.f ====
hdl/aluPkg.sv
hdl/isaPkg.sv
hdl/cla4.sv
hdl/shifter.sv
hdl/alu.sv
hdl/aluControl.sv
hdl/flagEval.sv
hdl/executeStage.sv
testbench/executeStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f vlog.f --top-module executeStageTb -o executeStageSim

./obj_dir/executeStageSim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi

echo "simulation clean"

// ==== testbench/executeStageTb.sv ====
module executeStageTb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [aluPkg::dataWidth-1:0] wordT;

    typedef struct packed {
        logic taken;
        wordT result;
    } expectT;

    logic          clk;
    logic          arstN;
    logic          inValid;
    isaPkg::instrT instr;
    logic          outValid;
    wordT          result;
    logic          branchTaken;

    int checkCount = 0;
    int errorCount = 0;

    wordT corners[4] = '{16'h0000, 16'h7FFF, 16'h8000, 16'hFFFF};

    executeStage dut0 (
        .clk         (clk),
        .arstN       (arstN),
        .inValid     (inValid),
        .instr       (instr),
        .outValid    (outValid),
        .result      (result),
        .branchTaken (branchTaken)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    // ******************************************************************
    // Reference model and compare tasks
    // ******************************************************************

    function automatic expectT model(isaPkg::opcodeT op, wordT a, wordT b);
        expectT      e;
        logic [16:0] wide;
        int          amt;
        wordT        r;
        e.taken = 1'b0;
        amt = int'(b[3:0]);  // Upper bits of B play no part in shifts.
        r = a;
        wide = {1'b0, a} + {1'b0, b};
        case (op)
            isaPkg::ADD:  e.result = a + b;
            isaPkg::SUB:  e.result = a - b;
            isaPkg::XOR:  e.result = a ^ b;
            isaPkg::ANDN: e.result = a & ~b;
            isaPkg::ROL: begin
                for (int i = 0; i < amt; i++) begin
                    r = {r[14:0], r[15]};
                end
                e.result = r;
            end
            isaPkg::SLL:  e.result = a << amt;
            isaPkg::ROR: begin
                for (int i = 0; i < amt; i++) begin
                    r = {r[0], r[15:1]};
                end
                e.result = r;
            end
            isaPkg::SRL:  e.result = a >> amt;
            isaPkg::SEQ:  e.result = {15'd0, a == b};
            isaPkg::SLT:  e.result = {15'd0, $signed(a) < $signed(b)};
            isaPkg::SLE:  e.result = {15'd0, $signed(a) <= $signed(b)};
            isaPkg::SCO:  e.result = {15'd0, wide[16]};
            default: begin
                e.result = a;  // Branches pass A through.
                case (op)
                    isaPkg::BEQZ: e.taken = (a == 16'h0000);
                    isaPkg::BNEZ: e.taken = (a != 16'h0000);
                    isaPkg::BLTZ: e.taken = a[15];
                    default:      e.taken = ~a[15];
                endcase
            end
        endcase
        return e;
    endfunction

    function automatic wordT randWord();
        int unsigned r;
        r = $urandom();
        return r[15:0];
    endfunction

    task automatic checkResult(string name, wordT expected, wordT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkTaken(string name, logic expected, logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkValid(logic expected, logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0d ns: outValid expected %b, got %b", $time, expected, actual);
        end
    endtask

    task automatic reportTest(string name, int startErrors);
        $display("test %-8s done, %0d errors", name, errorCount - startErrors);
    endtask

    task automatic driveInstr(isaPkg::opcodeT op, wordT a, wordT b);
        instr.opcode = op;
        instr.operandA = a;
        instr.operandB = b;
        inValid = 1'b1;
    endtask

    // One instruction in, then wait for its outValid and compare.
    task automatic runOne(isaPkg::opcodeT op, wordT a, wordT b);
        expectT exp;
        int     cycles;
        exp = model(op, a, b);
        @(posedge clk);
        #1;
        driveInstr(op, a, b);
        @(posedge clk);
        #1;
        inValid = 1'b0;
        cycles = 0;
        while (!outValid && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!outValid) begin
            errorCount++;
            $display("Timeout at %0d ns: no outValid within 20 cycles after %s",
                     $time, op.name());
        end else begin
            checkResult($sformatf("result (%s)", op.name()), exp.result, result);
            checkTaken($sformatf("branchTaken (%s)", op.name()), exp.taken, branchTaken);
        end
    endtask

    // ******************************************************************
    // Directed tests
    // ******************************************************************

    task automatic testReset();
        int startErrors;
        startErrors = errorCount;
        arstN = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            driveInstr(isaPkg::BEQZ, 16'h0000, 16'h0000);  // Would set taken if loaded.
            checkValid(1'b0, outValid);
            checkResult("result", 16'h0000, result);
            checkTaken("branchTaken", 1'b0, branchTaken);
        end
        inValid = 1'b0;
        arstN = 1'b1;
        @(posedge clk);
        #1;
        checkValid(1'b0, outValid);
        checkResult("result", 16'h0000, result);
        checkTaken("branchTaken", 1'b0, branchTaken);
        reportTest("reset", startErrors);
    endtask

    task automatic testArith();
        isaPkg::opcodeT ops[4];
        int             startErrors;
        startErrors = errorCount;
        ops = '{isaPkg::ADD, isaPkg::SUB, isaPkg::XOR, isaPkg::ANDN};
        foreach (ops[k]) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    runOne(ops[k], corners[i], corners[j]);
                end
            end
            for (int n = 0; n < 50; n++) begin
                runOne(ops[k], randWord(), randWord());
            end
        end
        reportTest("arith", startErrors);
    endtask

    task automatic testShift();
        isaPkg::opcodeT ops[4];
        wordT           b;
        int             startErrors;
        startErrors = errorCount;
        ops = '{isaPkg::ROL, isaPkg::SLL, isaPkg::ROR, isaPkg::SRL};
        foreach (ops[k]) begin
            for (int amt = 0; amt < 16; amt++) begin
                b = randWord();
                b[3:0] = amt[3:0];
                runOne(ops[k], randWord(), b);
            end
        end
        reportTest("shift", startErrors);
    endtask

    task automatic testSet();
        isaPkg::opcodeT ops[4];
        wordT           pairA[7];
        wordT           pairB[7];
        int             startErrors;
        startErrors = errorCount;
        ops = '{isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE, isaPkg::SCO};
        pairA = '{16'h1234, 16'h7FFF, 16'h8000, 16'hFFFF, 16'h8000, 16'h0000, 16'hFFFF};
        pairB = '{16'h1234, 16'h8000, 16'h7FFF, 16'h0001, 16'h8000, 16'h0000, 16'hFFFF};
        foreach (ops[k]) begin
            foreach (pairA[i]) begin
                runOne(ops[k], pairA[i], pairB[i]);
            end
            for (int n = 0; n < 20; n++) begin
                runOne(ops[k], randWord(), randWord());
            end
        end
        reportTest("set", startErrors);
    endtask

    task automatic testBranch();
        isaPkg::opcodeT ops[4];
        wordT           values[4];
        int             startErrors;
        startErrors = errorCount;
        ops = '{isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ};
        values = '{16'h0000, 16'h0123, 16'hF00D, 16'h8000};
        foreach (ops[k]) begin
            foreach (values[i]) begin
                runOne(ops[k], values[i], randWord());
            end
        end
        runOne(isaPkg::BEQZ, 16'h0000, 16'h0000);
        runOne(isaPkg::ADD, 16'h0000, 16'h0000);  // Taken must drop back to 0.
        reportTest("branch", startErrors);
    endtask

    task automatic testBurst();
        expectT         exp[20];
        isaPkg::opcodeT op;
        wordT           a;
        wordT           b;
        int unsigned    r;
        int             startErrors;
        startErrors = errorCount;
        for (int i = 0; i <= 20; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                checkValid(1'b1, outValid);
                checkResult($sformatf("result (burst %0d)", i - 1), exp[i-1].result, result);
                checkTaken($sformatf("branchTaken (burst %0d)", i - 1), exp[i-1].taken,
                           branchTaken);
            end
            if (i < 20) begin
                r = $urandom();
                op = isaPkg::opcodeT'({1'b0, r[3:0]});
                a = randWord();
                b = randWord();
                exp[i] = model(op, a, b);
                driveInstr(op, a, b);
            end else begin
                inValid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        checkValid(1'b0, outValid);
        reportTest("burst", startErrors);
    endtask

    initial begin
        void'($urandom(45));
        arstN = 1'b0;
        inValid = 1'b0;
        instr = '0;
        testReset();
        testArith();
        testShift();
        testSet();
        testBranch();
        testBurst();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/executeStage.sv ====
module executeStage (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         inValid,
    input  isaPkg::instrT                instr,
    output logic                         outValid,
    output logic [aluPkg::dataWidth-1:0] result,
    output logic                         branchTaken
);

    aluPkg::aluCtrlT              aluCtrl;
    aluPkg::aluFlagsT             aluFlags;
    logic [aluPkg::dataWidth-1:0] aluOut;
    logic [aluPkg::dataWidth-1:0] evalResult;
    logic                         evalTaken;

    aluControl aluControl0 (
        .instr (instr),
        .ctrl  (aluCtrl)
    );

    alu alu0 (
        .a     (instr.operandA),
        .b     (instr.operandB),
        .ctrl  (aluCtrl),
        .out   (aluOut),
        .flags (aluFlags)
    );

    flagEval flagEval0 (
        .opcode (instr.opcode),
        .aluOut (aluOut),
        .flags  (aluFlags),
        .result (evalResult),
        .taken  (evalTaken)
    );

    // ******************************************************************
    // Output register, one cycle after the strobe
    // ******************************************************************

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            result <= '0;
            branchTaken <= 1'b0;
        end else begin
            outValid <= inValid;
            if (inValid) begin
                result <= evalResult;       // Held until the next instruction.
                branchTaken <= evalTaken;
            end
        end
    end

endmodule

// ==== hdl/flagEval.sv ====
module flagEval (
    input  isaPkg::opcodeT               opcode,
    input  logic [aluPkg::dataWidth-1:0] aluOut,
    input  aluPkg::aluFlagsT             flags,
    output logic [aluPkg::dataWidth-1:0] result,
    output logic                         taken
);

    logic lessThan;
    logic setBit;
    logic isSet;

    // Signed A < B holds when the sign of A - B disagrees with overflow.
    assign lessThan = flags.ltZero ^ flags.ofl;

    always_comb begin
        isSet = 1'b1;
        case (opcode)
            isaPkg::SEQ: setBit = flags.zero;
            isaPkg::SLT: setBit = lessThan;
            isaPkg::SLE: setBit = lessThan | flags.zero;
            isaPkg::SCO: setBit = flags.cout;
            default: begin
                setBit = 1'b0;
                isSet = 1'b0;
            end
        endcase
    end

    assign result = isSet ? {{aluPkg::msb{1'b0}}, setBit} : aluOut;

    always_comb begin
        case (opcode)
            isaPkg::BEQZ: taken = flags.zero;
            isaPkg::BNEZ: taken = ~flags.zero;
            isaPkg::BLTZ: taken = flags.ltZero;    // Signed mode, so this is A[15].
            isaPkg::BGEZ: taken = ~flags.ltZero;
            default:      taken = 1'b0;
        endcase
    end

endmodule

// ==== hdl/aluControl.sv ====
module aluControl (
    input  isaPkg::instrT   instr,
    output aluPkg::aluCtrlT ctrl
);

    always_comb begin
        ctrl.op = aluPkg::ADD;  // Plain add unless the opcode says otherwise.
        ctrl.invA = 1'b0;
        ctrl.invB = 1'b0;
        ctrl.cin = 1'b0;
        ctrl.sign = 1'b1;
        ctrl.zeroB = 1'b0;

        case (instr.opcode)
            // **************************************************************
            // Arithmetic and logic
            // **************************************************************
            isaPkg::ADD: ctrl.op = aluPkg::ADD;
            isaPkg::SUB: begin
                ctrl.invB = 1'b1;  // A + ~B + 1.
                ctrl.cin = 1'b1;
            end
            isaPkg::XOR: ctrl.op = aluPkg::XOR;
            isaPkg::ANDN: begin
                ctrl.op = aluPkg::AND;
                ctrl.invB = 1'b1;
            end

            isaPkg::ROL: ctrl.op = aluPkg::ROL;
            isaPkg::SLL: ctrl.op = aluPkg::SLL;
            isaPkg::ROR: ctrl.op = aluPkg::ROR;
            isaPkg::SRL: ctrl.op = aluPkg::SRL;

            // **************************************************************
            // Compares, read back through the flags
            // **************************************************************
            isaPkg::SEQ,
            isaPkg::SLT,
            isaPkg::SLE: begin
                ctrl.invB = 1'b1;
                ctrl.cin = 1'b1;
            end
            isaPkg::SCO: ctrl.sign = 1'b0;  // Carry out of A + B.

            isaPkg::BEQZ,
            isaPkg::BNEZ,
            isaPkg::BLTZ,
            isaPkg::BGEZ: ctrl.zeroB = 1'b1;  // Result is A itself.

            default: ctrl.op = aluPkg::ADD;
        endcase
    end

endmodule

// ==== hdl/alu.sv ====
module alu (
    input  logic [aluPkg::dataWidth-1:0] a,
    input  logic [aluPkg::dataWidth-1:0] b,
    input  aluPkg::aluCtrlT              ctrl,
    output logic [aluPkg::dataWidth-1:0] out,
    output aluPkg::aluFlagsT             flags
);

    logic [aluPkg::msb:0] maskedB;
    logic [aluPkg::msb:0] inA;
    logic [aluPkg::msb:0] inB;
    logic [aluPkg::msb:0] shiftOut;
    logic [aluPkg::msb:0] sumOut;
    logic [aluPkg::dataWidth/4:0] carry;

    // ******************************************************************
    // Operand conditioning
    // ******************************************************************

    assign maskedB = ctrl.zeroB ? '0 : b;   // Branches compare A with zero.
    assign inA = ctrl.invA ? ~a : a;
    assign inB = ctrl.invB ? ~maskedB : maskedB;

    shifter shifter0 (
        .in  (inA),
        .cnt (inB[3:0]),
        .op  (ctrl.op[1:0]),
        .out (shiftOut)
    );

    // ******************************************************************
    // Adder, a ripple of lookahead nibbles
    // ******************************************************************

    assign carry[0] = ctrl.cin;

    for (genvar n = 0; n < aluPkg::dataWidth / 4; n++) begin : gNibble
        cla4 cla4i (
            .a    (inA[4*n +: 4]),
            .b    (inB[4*n +: 4]),
            .cin  (carry[n]),
            .sum  (sumOut[4*n +: 4]),
            .cout (carry[n + 1])
        );
    end

    always_comb begin
        case (ctrl.op)
            aluPkg::ROL,
            aluPkg::SLL,
            aluPkg::ROR,
            aluPkg::SRL:  out = shiftOut;
            aluPkg::ADD,
            aluPkg::ADD2: out = sumOut;
            aluPkg::XOR:  out = inA ^ inB;
            default:      out = inA & inB;
        endcase
    end

    // ******************************************************************
    // Flags
    // ******************************************************************

    always_comb begin
        flags.cout = carry[aluPkg::dataWidth/4];
        flags.zero = (out == '0);
        if (ctrl.sign) begin
            flags.ofl = (inA[aluPkg::msb] & inB[aluPkg::msb] & ~sumOut[aluPkg::msb])
                      | (~inA[aluPkg::msb] & ~inB[aluPkg::msb] & sumOut[aluPkg::msb]);
            flags.ltZero = out[aluPkg::msb];
        end else begin
            flags.ofl = carry[aluPkg::dataWidth/4];  // Unsigned overflow is the carry.
            flags.ltZero = 1'b0;
        end
    end

endmodule

// ==== hdl/shifter.sv ====
module shifter (
    input  logic [aluPkg::dataWidth-1:0] in,
    input  logic [3:0]                   cnt,
    input  logic [1:0]                   op,
    output logic [aluPkg::dataWidth-1:0] out
);

    // Stage k moves the word by 2**k when cnt[k] is set.
    logic [$bits(cnt):0][aluPkg::msb:0] stage;

    assign stage[0] = in;

    for (genvar i = 0; i < $bits(cnt); i++) begin : gStage
        logic [aluPkg::msb:0] cur;
        logic [aluPkg::msb:0] moved;

        assign cur = stage[i];

        always_comb begin
            case (op)
                2'b00: moved = (cur << (1 << i))
                             | (cur >> (aluPkg::dataWidth - (1 << i)));  // Rotate left.
                2'b01: moved = cur << (1 << i);                           // Zero fill.
                2'b10: moved = (cur >> (1 << i))
                             | (cur << (aluPkg::dataWidth - (1 << i)));  // Rotate right.
                default: moved = cur >> (1 << i);                        // Logical right.
            endcase
        end

        assign stage[i + 1] = cnt[i] ? moved : cur;
    end

    assign out = stage[$bits(cnt)];

endmodule

// ==== hdl/cla4.sv ====
module cla4 (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic       cin,
    output logic [3:0] sum,
    output logic       cout
);

    logic [3:0] g;
    logic [3:0] p;
    logic [4:0] c;

    assign g = a & b;
    assign p = a ^ b;

    // Every carry is formed directly from the block inputs.
    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & c[0]);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & c[0]);
    assign c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0])
                | (p[3] & p[2] & p[1] & p[0] & c[0]);

    assign sum  = p ^ c[3:0];
    assign cout = c[4];

endmodule

// ==== hdl/isaPkg.sv ====
package isaPkg;

    // ******************************************************************
    // Instruction opcodes seen by the execute stage
    // ******************************************************************

    typedef enum logic [4:0] {
        ADD  = 5'd0,   // A plus B.
        SUB  = 5'd1,   // A minus B.
        XOR  = 5'd2,
        ANDN = 5'd3,   // A and not B.
        ROL  = 5'd4,   // Shift group, amount in B[3:0].
        SLL  = 5'd5,
        ROR  = 5'd6,
        SRL  = 5'd7,
        SEQ  = 5'd8,   // Set group, result is 0 or 1.
        SLT  = 5'd9,
        SLE  = 5'd10,
        SCO  = 5'd11,
        BEQZ = 5'd12,  // Branch group, compares A with zero.
        BNEZ = 5'd13,
        BLTZ = 5'd14,
        BGEZ = 5'd15
    } opcodeT;

    // Immediates are already placed in operandB upstream.
    typedef struct packed {
        opcodeT                          opcode;
        logic [aluPkg::dataWidth-1:0]    operandA;
        logic [aluPkg::dataWidth-1:0]    operandB;
    } instrT;

endpackage

// ==== hdl/aluPkg.sv ====
package aluPkg;

    localparam int dataWidth = 16;
    localparam int msb = dataWidth - 1;  // Sign bit position.

    // ******************************************************************
    // ALU operation codes, shift group in the low half
    // ******************************************************************

    typedef enum logic [2:0] {
        ROL  = 3'd0,
        SLL  = 3'd1,
        ROR  = 3'd2,
        SRL  = 3'd3,
        ADD  = 3'd4,
        ADD2 = 3'd5,   // Same adder path as ADD.
        XOR  = 3'd6,
        AND  = 3'd7
    } aluOpT;

    typedef struct packed {
        aluOpT op;
        logic  invA;   // Invert operand A before use.
        logic  invB;   // Invert operand B after masking.
        logic  cin;    // Carry into the lowest adder.
        logic  sign;   // Signed flags.
        logic  zeroB;  // Force operand B to zero.
    } aluCtrlT;

    typedef struct packed {
        logic ofl;
        logic cout;
        logic zero;    // Result is all zeros.
        logic ltZero;
    } aluFlagsT;

endpackage
